// File: design/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// architectural register address, x0..x31
`define REG_ADDR_WIDTH 5

// long-instruction tag, 0 reserved as "no tag"
`define TAG_WIDTH 3

// scoreboard entries incl. the reserved index 0
`define SB_DEPTH 8

// issue-to-commit distance of the long unit, in cycles
`define LONG_LATENCY 4

`endif

// File: design/issue_pkg.sv
`include "issue_params.svh"

package issue_pkg;

    // one decoded instruction as seen by the issue stage
    typedef struct packed {
        logic                       valid;      // slot holds an instruction
        logic                       rd_we;      // writes rd
        logic                       is_long;    // multi-cycle, result tracked
        logic                       is_branch;
        logic                       is_jump;    // always issues alone
        logic                       is_csr;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
    } inst_info_t;

    // completion pulse out of the long pipeline
    typedef struct packed {
        logic                       valid;
        logic [`TAG_WIDTH-1:0]      tag;        // scoreboard index to free
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } commit_t;

endpackage

// File: design/hazard_unit.sv
`include "issue_params.svh"

module hazard_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::inst_info_t inst_a_i,     // older slot
    input  issue_pkg::inst_info_t inst_b_i,
    input  issue_pkg::commit_t    commit_a_i,
    input  issue_pkg::commit_t    commit_b_i,
    output logic [1:0]            issue_o,      // bit0 slot A, bit1 slot B
    output logic [`TAG_WIDTH-1:0] tag_a_o,
    output logic [`TAG_WIDTH-1:0] tag_b_o,
    output logic                  stall_o,
    output logic                  busy_o
);

    // scoreboard, index 0 never allocated
    logic [`SB_DEPTH-1:0]       sb_valid_q;
    logic [`REG_ADDR_WIDTH-1:0] sb_rd_q [`SB_DEPTH];
    logic [`SB_DEPTH-1:0]       sb_live;      // valid and not committing now
    logic [`SB_DEPTH-1:0]       sb_mask_b;    // occupancy as seen by slot B

    logic                       a_vld, b_vld;
    logic                       a_wr, b_wr;   // writes a nonzero rd
    logic                       a_need, b_need; // wants a scoreboard slot
    logic                       conflict_a, conflict_b;
    logic                       dep_b;        // B depends on A within the pair
    logic [`TAG_WIDTH-1:0]      slot_a, slot_b;
    logic                       full_a, full_b;
    logic [1:0]                 issue_raw;

    // branch serialization
    logic                       branch_now;
    logic                       branch_seen_q; // edge register, branch already seen in A
    logic                       branch_edge;
    logic                       ser_q;
    logic                       ser_active;

    // lowest free index in 1..DEPTH-1, 0 if none
    function automatic logic [`TAG_WIDTH-1:0] lowest_free(input logic [`SB_DEPTH-1:0] used);
        logic [`TAG_WIDTH-1:0] idx;
        idx = '0;
        for (int i = `SB_DEPTH - 1; i >= 1; i--) begin
            if (!used[i]) idx = `TAG_WIDTH'(i); // last hit wins -> lowest
        end
        return idx;
    endfunction

    // does inst read or write addr, x0 excluded
    function automatic logic touches(input issue_pkg::inst_info_t inst,
                                     input logic [`REG_ADDR_WIDTH-1:0] addr);
        logic hit;
        hit = 1'b0;
        if (inst.rs1 != '0 && inst.rs1 == addr) hit = 1'b1;           // raw
        if (inst.rs2 != '0 && inst.rs2 == addr) hit = 1'b1;           // raw
        if (inst.rd_we && inst.rd != '0 && inst.rd == addr) hit = 1'b1; // waw
        return hit;
    endfunction

    assign a_vld  = inst_a_i.valid;
    assign b_vld  = inst_b_i.valid;
    assign a_wr   = inst_a_i.rd_we && (inst_a_i.rd != '0);
    assign b_wr   = inst_b_i.rd_we && (inst_b_i.rd != '0);
    assign a_need = a_vld && inst_a_i.is_long && (a_wr || inst_a_i.is_csr);
    assign b_need = b_vld && inst_b_i.is_long && (b_wr || inst_b_i.is_csr);

    // scoreboard compare, commits of this cycle already released
    always_comb begin
        sb_live    = '0;
        conflict_a = 1'b0;
        conflict_b = 1'b0;
        for (int i = 1; i < `SB_DEPTH; i++) begin
            sb_live[i] = sb_valid_q[i]
                       && !(commit_a_i.valid && commit_a_i.tag == `TAG_WIDTH'(i))
                       && !(commit_b_i.valid && commit_b_i.tag == `TAG_WIDTH'(i));
            if (sb_live[i] && a_vld && touches(inst_a_i, sb_rd_q[i])) conflict_a = 1'b1;
            if (sb_live[i] && b_vld && touches(inst_b_i, sb_rd_q[i])) conflict_b = 1'b1;
        end
    end

    // in-pair dependency, csr pairs never dual issue
    assign dep_b = a_vld && b_vld
                && ((a_wr && touches(inst_b_i, inst_a_i.rd))
                    || (inst_a_i.is_csr && inst_b_i.is_csr));

    // tag search, A first, B gets the next one
    // freed entries come back only the cycle after commit
    always_comb begin
        slot_a    = lowest_free(sb_valid_q);
        sb_mask_b = sb_valid_q;
        if (a_need) sb_mask_b[slot_a] = 1'b1;
        slot_b    = lowest_free(sb_mask_b);
    end

    assign full_a = a_need && (slot_a == '0);
    assign full_b = b_need && (slot_b == '0);

    assign branch_now  = a_vld && inst_a_i.is_branch;
    assign branch_edge = branch_now && !branch_seen_q;
    assign ser_active  = branch_edge || ser_q;

    // priority chain
    always_comb begin
        if (a_vld && inst_a_i.is_jump) begin
            issue_raw = 2'b01;      // jump alone
        end else if (conflict_a || full_a) begin
            issue_raw = 2'b00;      // A blocked -> nothing, keep order
        end else if (ser_active) begin
            issue_raw = 2'b01;      // branch serialize
        end else if (conflict_b || full_b || dep_b) begin
            issue_raw = 2'b01;
        end else begin
            issue_raw = 2'b11;
        end
    end

    assign issue_o = issue_raw & {b_vld, a_vld};     // empty slots never issue
    assign stall_o = (issue_o != {b_vld, a_vld});    // something valid left behind
    assign tag_a_o = (issue_o[0] && a_need) ? slot_a : '0;
    assign tag_b_o = (issue_o[1] && b_need) ? slot_b : '0;
    assign busy_o  = |sb_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_valid_q    <= '0;
            branch_seen_q <= 1'b0;
            ser_q         <= 1'b0;
        end else begin
            // release first, allocation never hits a still-valid entry
            if (commit_a_i.valid) sb_valid_q[commit_a_i.tag] <= 1'b0;
            if (commit_b_i.valid) sb_valid_q[commit_b_i.tag] <= 1'b0;
            if (tag_a_o != '0) sb_valid_q[tag_a_o] <= 1'b1;
            if (tag_b_o != '0) sb_valid_q[tag_b_o] <= 1'b1;
            // rearm once A leaves, so back-to-back branches each serialize
            branch_seen_q <= branch_now && !issue_o[0];
            // held while the branch waits on the scoreboard
            ser_q         <= ser_active && conflict_a;
        end
    end

    // rd payload, a write-less csr stores x0 so it never matches
    always_ff @(posedge clk) begin
        if (tag_a_o != '0) sb_rd_q[tag_a_o] <= a_wr ? inst_a_i.rd : '0;
        if (tag_b_o != '0) sb_rd_q[tag_b_o] <= b_wr ? inst_b_i.rd : '0;
    end

endmodule

// File: design/long_exec_pipe.sv
`include "issue_params.svh"

module long_exec_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,  // issued long instruction this cycle
    input  logic [`TAG_WIDTH-1:0]      tag_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    output issue_pkg::commit_t         commit_o
);

    localparam int LAT = `LONG_LATENCY;

    // stage 0 is loaded at the issue edge, stage LAT-1 is the commit
    logic [LAT-1:0]             vld_q;
    logic [`TAG_WIDTH-1:0]      tag_q [LAT];
    logic [`REG_ADDR_WIDTH-1:0] rd_q  [LAT];

    // valid chain, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int i = 1; i < LAT; i++) begin
                vld_q[i] <= vld_q[i-1]; // never stalls
            end
        end
    end

    // payload follows its valid bit
    always_ff @(posedge clk) begin
        tag_q[0] <= tag_i;
        rd_q[0]  <= rd_i;
        for (int i = 1; i < LAT; i++) begin
            tag_q[i] <= tag_q[i-1];
            rd_q[i]  <= rd_q[i-1];
        end
    end

    // one cycle pulse per instruction
    always_comb begin
        commit_o.valid = vld_q[LAT-1];
        commit_o.tag   = tag_q[LAT-1];
        commit_o.rd    = rd_q[LAT-1];
    end

endmodule

// File: design/issue_top.sv
`include "issue_params.svh"

module issue_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::inst_info_t inst_a_i,
    input  issue_pkg::inst_info_t inst_b_i,
    output logic [1:0]            issue_o,
    output logic [`TAG_WIDTH-1:0] tag_a_o,
    output logic [`TAG_WIDTH-1:0] tag_b_o,
    output logic                  stall_o,   // decode holds the pair
    output logic                  busy_o,    // long result outstanding
    output issue_pkg::commit_t    commit_a_o,
    output issue_pkg::commit_t    commit_b_o
);

    logic [1:0]            issue;
    logic [`TAG_WIDTH-1:0] tag_a, tag_b;
    issue_pkg::commit_t    commit_a, commit_b; // fed back to the scoreboard

    hazard_unit u_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_a_i   (inst_a_i),
        .inst_b_i   (inst_b_i),
        .commit_a_i (commit_a),
        .commit_b_i (commit_b),
        .issue_o    (issue),
        .tag_a_o    (tag_a),
        .tag_b_o    (tag_b),
        .stall_o    (stall_o),
        .busy_o     (busy_o)
    );

    // a lane only starts on a tracked long issue
    long_exec_pipe lane_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (issue[0] && (tag_a != '0)),
        .tag_i    (tag_a),
        .rd_i     (inst_a_i.rd),
        .commit_o (commit_a)
    );

    long_exec_pipe lane_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (issue[1] && (tag_b != '0)),
        .tag_i    (tag_b),
        .rd_i     (inst_b_i.rd),
        .commit_o (commit_b)
    );

    assign issue_o    = issue;
    assign tag_a_o    = tag_a;
    assign tag_b_o    = tag_b;
    assign commit_a_o = commit_a;
    assign commit_b_o = commit_b;

endmodule

// File: test/tb_issue_model.svh
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// expected response of one cycle, plus the next branch state
typedef struct packed {
    logic [1:0]            issue;
    logic [`TAG_WIDTH-1:0] tag_a;
    logic [`TAG_WIDTH-1:0] tag_b;
    logic                  stall;
    logic                  busy;
    issue_pkg::commit_t    commit_a;
    issue_pkg::commit_t    commit_b;
    logic                  ser_next;   // single issue held
    logic                  seen_next;  // branch already met in A
} exp_t;

logic [`SB_DEPTH-1:0]       m_valid;
logic [`REG_ADDR_WIDTH-1:0] m_rd [`SB_DEPTH];   // x0 when nothing written
logic                       m_ser;
logic                       m_seen;
int                         m_cycle;
issue_pkg::commit_t         pend_a[$];          // lane a, oldest first
issue_pkg::commit_t         pend_b[$];
int                         due_a[$];           // commit cycle of each entry
int                         due_b[$];

task automatic model_reset();
    m_valid = '0;
    m_ser   = 1'b0;
    m_seen  = 1'b0;
    m_cycle = 0;
    for (int i = 0; i < `SB_DEPTH; i++) begin
        m_rd[i] = '0;
    end
    pend_a.delete();
    pend_b.delete();
    due_a.delete();
    due_b.delete();
endtask

// lowest unused index, 0 = none
function automatic logic [`TAG_WIDTH-1:0] first_free(input logic [`SB_DEPTH-1:0] used);
    logic [`TAG_WIDTH-1:0] pick;
    logic                  found;
    pick  = '0;
    found = 1'b0;
    for (int i = 1; i < `SB_DEPTH; i++) begin
        if (!found && !used[i]) begin
            pick  = `TAG_WIDTH'(i);
            found = 1'b1;
        end
    end
    return pick;
endfunction

// raw or waw against a live entry, entries holding x0 never match
function automatic logic hits_sb(input issue_pkg::inst_info_t x,
                                 input logic [`SB_DEPTH-1:0] live);
    logic hit;
    hit = 1'b0;
    for (int i = 1; i < `SB_DEPTH; i++) begin
        if (live[i] && m_rd[i] != '0) begin
            if (x.rs1 == m_rd[i] || x.rs2 == m_rd[i]) hit = 1'b1;
            if (x.rd_we && x.rd == m_rd[i]) hit = 1'b1;
        end
    end
    return x.valid && hit;
endfunction

function automatic exp_t predict(input issue_pkg::inst_info_t a, input issue_pkg::inst_info_t b);
    exp_t                  e;
    logic [`SB_DEPTH-1:0]  live, used_b;
    logic                  a_w, b_w, a_n, b_n, ca, cb, dep, ser;
    logic [`TAG_WIDTH-1:0] ta, tb;
    e = '0;
    if (due_a.size() != 0 && due_a[0] == m_cycle) e.commit_a = pend_a[0];
    if (due_b.size() != 0 && due_b[0] == m_cycle) e.commit_b = pend_b[0];
    live = m_valid;                                  // commits release at once
    if (e.commit_a.valid) live[e.commit_a.tag] = 1'b0;
    if (e.commit_b.valid) live[e.commit_b.tag] = 1'b0;
    a_w = a.rd_we && a.rd != '0;
    b_w = b.rd_we && b.rd != '0;
    a_n = a.valid && a.is_long && (a_w || a.is_csr);
    b_n = b.valid && b.is_long && (b_w || b.is_csr);
    ca  = hits_sb(a, live);
    cb  = hits_sb(b, live);
    dep = a.valid && b.valid && ((a.is_csr && b.is_csr)
        || (a_w && (b.rs1 == a.rd || b.rs2 == a.rd || (b.rd_we && b.rd == a.rd))));
    ta     = first_free(m_valid);                    // slot frees a cycle after commit
    used_b = m_valid;
    if (a_n) used_b[ta] = 1'b1;
    tb  = first_free(used_b);
    ser = (a.valid && a.is_branch && !m_seen) || m_ser;
    if (a.valid && a.is_jump) e.issue = 2'b01;
    else if (ca || (a_n && ta == '0)) e.issue = 2'b00;
    else if (ser) e.issue = 2'b01;
    else if (cb || dep || (b_n && tb == '0)) e.issue = 2'b01;
    else e.issue = 2'b11;
    e.issue     = e.issue & {b.valid, a.valid};
    e.stall     = e.issue != {b.valid, a.valid};
    e.tag_a     = (e.issue[0] && a_n) ? ta : '0;
    e.tag_b     = (e.issue[1] && b_n) ? tb : '0;
    e.busy      = |m_valid;
    e.ser_next  = ser && ca;
    e.seen_next = a.valid && a.is_branch && !e.issue[0];
    return e;
endfunction

// move model one cycle ahead from its own expectation
task automatic advance(input issue_pkg::inst_info_t a, input issue_pkg::inst_info_t b,
                       input exp_t e);
    issue_pkg::commit_t c;
    if (e.commit_a.valid) begin
        m_valid[e.commit_a.tag] = 1'b0;
        pend_a.delete(0);
        due_a.delete(0);
    end
    if (e.commit_b.valid) begin
        m_valid[e.commit_b.tag] = 1'b0;
        pend_b.delete(0);
        due_b.delete(0);
    end
    if (e.tag_a != '0) begin
        m_valid[e.tag_a] = 1'b1;
        m_rd[e.tag_a]    = a.rd_we ? a.rd : '0;
        c = {1'b1, e.tag_a, a.rd};                  // lane carries the raw rd
        pend_a.push_back(c);
        due_a.push_back(m_cycle + `LONG_LATENCY);
    end
    if (e.tag_b != '0) begin
        m_valid[e.tag_b] = 1'b1;
        m_rd[e.tag_b]    = b.rd_we ? b.rd : '0;
        c = {1'b1, e.tag_b, b.rd};
        pend_b.push_back(c);
        due_b.push_back(m_cycle + `LONG_LATENCY);
    end
    m_ser  = e.ser_next;
    m_seen = e.seen_next;
    m_cycle++;
endtask

`endif

// File: test/tb_issue_top.sv
`include "issue_params.svh"

module tb_issue_top;

    localparam int STALL_LIMIT = 32;   // cycles a pair may wait
    localparam int DRAIN_LIMIT = 40;

    logic                  clk;
    logic                  rst_n;
    issue_pkg::inst_info_t inst_a, inst_b;
    logic [1:0]            issue;
    logic [`TAG_WIDTH-1:0] tag_a, tag_b;
    logic                  stall, busy;
    issue_pkg::commit_t    commit_a, commit_b;

    int errors = 0;
    int timeouts = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int seen_before = 0;   // problems before the current test
    int pair_cycles = 0;

    `include "tb_issue_model.svh"

    exp_t exp_now;

    issue_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_a_i   (inst_a),
        .inst_b_i   (inst_b),
        .issue_o    (issue),
        .tag_a_o    (tag_a),
        .tag_b_o    (tag_b),
        .stall_o    (stall),
        .busy_o     (busy),
        .commit_a_o (commit_a),
        .commit_b_o (commit_b)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("Error: %s expected %h got %h at cycle %0d", name, exp_v, got_v, m_cycle);
        errors++;
    endtask

    // compare on the falling edge, inputs and outputs settled
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            model_reset();
        end else begin
            exp_now = predict(inst_a, inst_b);
            if (issue !== exp_now.issue) report_mismatch("issue_o", 32'(exp_now.issue), 32'(issue));
            if (tag_a !== exp_now.tag_a) report_mismatch("tag_a_o", 32'(exp_now.tag_a), 32'(tag_a));
            if (tag_b !== exp_now.tag_b) report_mismatch("tag_b_o", 32'(exp_now.tag_b), 32'(tag_b));
            if (stall !== exp_now.stall) report_mismatch("stall_o", 32'(exp_now.stall), 32'(stall));
            if (busy !== exp_now.busy) report_mismatch("busy_o", 32'(exp_now.busy), 32'(busy));
            if (commit_a.valid !== exp_now.commit_a.valid
                || (exp_now.commit_a.valid && commit_a !== exp_now.commit_a))
                report_mismatch("commit_a_o", 32'(exp_now.commit_a), 32'(commit_a));
            if (commit_b.valid !== exp_now.commit_b.valid
                || (exp_now.commit_b.valid && commit_b !== exp_now.commit_b))
                report_mismatch("commit_b_o", 32'(exp_now.commit_b), 32'(commit_b));
            advance(inst_a, inst_b, exp_now);
        end
    end

    function automatic issue_pkg::inst_info_t make_inst(input int is_long, input int rd,
                                                        input int rs1, input int rs2);
        issue_pkg::inst_info_t x;
        x         = '0;
        x.valid   = 1'b1;
        x.rd_we   = 1'b1;
        x.is_long = (is_long != 0);
        x.rd      = `REG_ADDR_WIDTH'(rd);
        x.rs1     = `REG_ADDR_WIDTH'(rs1);
        x.rs2     = `REG_ADDR_WIDTH'(rs2);
        return x;
    endfunction

    // x0..x3 only, so conflicts are frequent
    function automatic issue_pkg::inst_info_t rand_inst();
        issue_pkg::inst_info_t x;
        x           = make_inst(0, 0, 0, 0);
        x.valid     = ($urandom % 8) != 0;
        x.rd_we     = ($urandom % 4) != 0;
        x.is_long   = ($urandom % 2) != 0;
        x.is_csr    = ($urandom % 8) == 0;
        x.is_branch = ($urandom % 8) == 0;
        x.is_jump   = ($urandom % 16) == 0;
        x.rd        = `REG_ADDR_WIDTH'($urandom % 4);
        x.rs1       = `REG_ADDR_WIDTH'($urandom % 4);
        x.rs2       = `REG_ADDR_WIDTH'($urandom % 4);
        return x;
    endfunction

    // present a pair, hold it while stalled, drop what already issued
    task automatic issue_pair(input issue_pkg::inst_info_t a, input issue_pkg::inst_info_t b);
        int waited;
        waited = 0;
        @(posedge clk);
        inst_a <= a;
        inst_b <= b;
        @(negedge clk);
        pair_cycles++;
        while (stall && waited < STALL_LIMIT) begin
            if (issue[0]) a.valid = 1'b0;
            if (issue[1]) b.valid = 1'b0;
            @(posedge clk);
            inst_a <= a;
            inst_b <= b;
            @(negedge clk);
            waited++;
            pair_cycles++;
        end
        if (stall) begin
            $display("timeout: pair still stalled after %0d cycles", waited);
            timeouts++;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        inst_a <= '0;
        inst_b <= '0;
        @(negedge clk);
        while (busy && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("timeout: scoreboard still busy after %0d cycles", waited);
            timeouts++;
        end
    endtask

    task automatic end_test(input string name);
        int found;
        @(posedge clk);                                  // last compare is done
        found = errors + timeouts - seen_before;
        tests_run++;
        if (found == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d problems", name, found);
            tests_failed++;
        end
        seen_before = errors + timeouts;
    endtask

    initial begin
        issue_pkg::inst_info_t a, b;
        rst_n  <= 1'b0;
        inst_a <= '0;
        inst_b <= '0;
        void'($urandom(34));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        issue_pair(make_inst(1, 1, 0, 0), make_inst(1, 2, 0, 0));   // tags 1 and 2
        wait_idle();
        end_test("independent pair");

        issue_pair(make_inst(1, 3, 0, 0), '0);
        issue_pair(make_inst(0, 4, 3, 0), make_inst(0, 5, 1, 2));   // raw on x3
        issue_pair(make_inst(1, 6, 0, 0), '0);
        issue_pair(make_inst(0, 7, 1, 2), make_inst(0, 6, 0, 0));   // waw only in B
        wait_idle();
        end_test("scoreboard conflict");

        issue_pair(make_inst(0, 8, 1, 0), make_inst(0, 9, 8, 0));   // B reads A's rd
        issue_pair(make_inst(0, 8, 0, 0), make_inst(0, 8, 2, 3));   // B writes A's rd
        a = make_inst(0, 10, 0, 0);
        a.is_csr = 1'b1;
        b = make_inst(0, 11, 0, 0);
        b.is_csr = 1'b1;
        issue_pair(a, b);
        issue_pair(make_inst(0, 0, 0, 0), make_inst(0, 12, 0, 0));  // x0 both ways
        a = make_inst(1, 0, 0, 0);
        a.is_csr = 1'b1;                                            // long csr, tracked
        issue_pair(a, make_inst(1, 0, 5, 6));                       // long to x0, no tag
        issue_pair(make_inst(0, 13, 0, 0), '0);                     // x0 vs csr entry
        wait_idle();
        end_test("pairing rules");

        a = make_inst(0, 14, 0, 0);
        a.is_jump = 1'b1;
        issue_pair(a, make_inst(0, 15, 0, 0));
        a = make_inst(0, 0, 1, 2);
        a.is_branch = 1'b1;
        issue_pair(a, make_inst(0, 16, 0, 0));
        issue_pair(make_inst(1, 9, 0, 0), '0);
        a = make_inst(0, 0, 9, 0);
        a.is_branch = 1'b1;                                         // waits on x9
        issue_pair(a, make_inst(0, 17, 0, 0));
        wait_idle();
        end_test("jump and branch");

        for (int i = 0; i < 3; i++) begin
            issue_pair(make_inst(1, 18 + 2 * i, 0, 0), make_inst(1, 19 + 2 * i, 0, 0));
        end
        issue_pair(make_inst(1, 24, 0, 0), make_inst(1, 25, 0, 0)); // one slot left
        wait_idle();
        for (int i = 0; i < 3; i++) begin
            issue_pair(make_inst(1, 18 + 2 * i, 0, 0), make_inst(1, 19 + 2 * i, 0, 0));
        end
        issue_pair(make_inst(1, 24, 0, 0), '0);
        issue_pair(make_inst(1, 25, 0, 0), make_inst(0, 26, 0, 0)); // all seven taken
        wait_idle();
        end_test("full scoreboard");

        pair_cycles = 0;
        while (pair_cycles < 300) begin
            issue_pair(rand_inst(), rand_inst());
        end
        wait_idle();
        end_test("random mix");

        $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
+incdir+test
design/issue_pkg.sv
design/hazard_unit.sv
design/long_exec_pipe.sv
design/issue_top.sv
test/tb_issue_top.sv

// File: run.sh
#!/bin/sh
# build and run the issue-control testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_issue_top \
    -Mdir obj_dir -o tb_issue_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_issue_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
